// File: src.f
source/icache_pkg.sv
source/cache_ram.sv
source/icache_decode.sv
source/icache_execute.sv
source/icache_result.sv
source/icache_top.sv
tests/icache_properties.sv
tests/tb_icache.sv

// File: tests/tb_icache.sv
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  localparam int RAND_OPS  = 400;
  localparam int DIR_OPS   = 80;                          // directed part, upper bound
  localparam int TOTAL_OPS = 5 + DIR_OPS + RAND_OPS + 10; // reset, tests, drain

  typedef struct packed {
    logic        hit;
    word_t       instr;
    logic [31:0] due;    // cycle the response must show up
  } exp_t;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  i_req_valid;
  addr_t i_req_addr;
  logic  o_req_ready;
  logic  i_fill_valid;
  fill_t i_fill;
  logic  o_rsp_valid;
  logic  o_rsp_hit;
  word_t o_rsp_instr;

  integer seed   = 32'haa1b;
  int     errors = 0;
  int     checks = 0;
  int     cyc    = 0;  // rising edges seen
  exp_t   exp_q[$];    // predicted responses, oldest first

  // ------------------------------
  // reference model state
  // ------------------------------
  tag_t   m_tag   [128][2];
  logic   m_valid [128][2];
  logic   m_lru   [128];   // next victim way
  line_t  m_line  [128][2];
  logic   pend_valid;      // hit waiting for its lru update
  index_t pend_set;
  logic   pend_way;

  tag_t   tag_pool [4] = '{20'h12345, 20'h0abcd, 20'h7f00e, 20'hc0de5};
  index_t idx_pool [3] = '{7'h05, 7'h2a, 7'h7f};  // few sets so they fill up

  always #2 clk = ~clk;  // 4 ns

  icache_top #(
    .DEPTH (128)
  ) dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_req_valid  (i_req_valid),
    .i_req_addr   (i_req_addr),
    .o_req_ready  (o_req_ready),
    .i_fill_valid (i_fill_valid),
    .i_fill       (i_fill),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_hit    (o_rsp_hit),
    .o_rsp_instr  (o_rsp_instr)
  );

  // ------------------------------
  // model, steps at each edge
  // ------------------------------
  always @(posedge clk)
  begin : model
    index_t fidx;
    index_t ridx;
    tag_t   rtag;
    int     word;
    logic   victim;
    logic   hit;
    logic   way;
    exp_t   e;
    cyc = cyc + 1;
    if (rst_n)
    begin
      for (int s = 0; s < 128; s++)
      begin
        m_valid[s][0] = 1'b0;
        m_valid[s][1] = 1'b0;
        m_lru[s]      = 1'b0;
      end
      pend_valid = 1'b0;
    end
    else
    begin
      checks++;
      if (o_req_ready !== !i_fill_valid)
      begin
        errors++;
        $display("error at %0t: o_req_ready %b with i_fill_valid %b", $time,
                 o_req_ready, i_fill_valid);
      end
      fidx   = i_fill.addr[11:5];
      ridx   = i_req_addr[11:5];
      rtag   = i_req_addr[31:12];
      word   = i_req_addr[4:2];
      victim = m_lru[fidx];  // lru as it was before this edge
      if (pend_valid)
      begin
        m_lru[pend_set] = ~pend_way;  // point at the other way
      end
      pend_valid = 1'b0;
      if (i_fill_valid)
      begin
        m_tag[fidx][victim]   = i_fill.addr[31:12];
        m_line[fidx][victim]  = i_fill.line;
        m_valid[fidx][victim] = 1'b1;
        m_lru[fidx]           = ~victim;  // fill wins over a hit update
      end
      else if (i_req_valid)
      begin
        hit = 1'b0;
        way = 1'b0;
        if (m_valid[ridx][0] && m_tag[ridx][0] == rtag)
        begin
          hit = 1'b1;
        end
        else if (m_valid[ridx][1] && m_tag[ridx][1] == rtag)
        begin
          hit = 1'b1;
          way = 1'b1;
        end
        e.hit   = hit;
        e.instr = hit ? m_line[ridx][way][word*32 +: 32] : '0;  // zero on a miss
        e.due   = cyc + 1;
        exp_q.push_back(e);
        pend_valid = hit;
        pend_set   = ridx;
        pend_way   = way;
      end
    end
  end

  // ------------------------------
  // response check, outputs settled
  // ------------------------------
  always @(negedge clk)
  begin : monitor
    exp_t e;
    if (!rst_n)
    begin
      if (o_rsp_valid)
      begin
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("a response came in cycle %0d with no lookup waiting for it", cyc);
        end
        else
        begin
          e = exp_q.pop_front();
          checks++;
          if (e.due != cyc)
          begin
            errors++;
            $display("error at %0t: response in cycle %0d, expected in %0d", $time, cyc, e.due);
          end
          if (o_rsp_hit !== e.hit || o_rsp_instr !== e.instr)
          begin
            errors++;
            $display("error at %0t: hit %b instr %h, expected hit %b instr %h", $time,
                     o_rsp_hit, o_rsp_instr, e.hit, e.instr);
          end
        end
      end
      else
      begin
        if (o_rsp_hit !== 1'b0 || o_rsp_instr !== '0)
        begin
          errors++;
          $display("error at %0t: idle output hit %b instr %h", $time, o_rsp_hit, o_rsp_instr);
        end
        if (exp_q.size() > 0 && exp_q[0].due <= cyc)
        begin
          errors++;
          $display("the response due in cycle %0d never came", exp_q[0].due);
          void'(exp_q.pop_front());
        end
      end
    end
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  function automatic addr_t make_addr(tag_t t, index_t i, int w);
    return {t, i, w[2:0], 2'b00};
  endfunction

  task automatic rand_line(output line_t l);
    for (int k = 0; k < 8; k++)
    begin
      l[k*32 +: 32] = $random(seed);
    end
  endtask

  task automatic pick_addr(output addr_t a);
    a = make_addr(tag_pool[{$random(seed)} % 4], idx_pool[{$random(seed)} % 3],
                  {$random(seed)} % 8);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    i_req_valid  = 1'b0;
    i_fill_valid = 1'b0;
  endtask

  task automatic lookup(addr_t a);
    @(negedge clk);
    i_req_valid  = 1'b1;
    i_req_addr   = a;
    i_fill_valid = 1'b0;
  endtask

  task automatic fill(addr_t a, line_t l);
    @(negedge clk);
    i_req_valid  = 1'b0;
    i_fill_valid = 1'b1;
    i_fill.addr  = a;
    i_fill.line  = l;
  endtask

  // request held off by the fill
  task automatic fill_and_lookup(addr_t fa, line_t l, addr_t ra);
    @(negedge clk);
    i_req_valid  = 1'b1;
    i_req_addr   = ra;
    i_fill_valid = 1'b1;
    i_fill.addr  = fa;
    i_fill.line  = l;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin : stimulus
    int    sel;
    addr_t a;
    addr_t b;
    line_t l;
    rst_n        = 1'b1;
    i_req_valid  = 1'b0;
    i_req_addr   = '0;
    i_fill_valid = 1'b0;
    i_fill       = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    for (int w = 0; w < 8; w++)
    begin
      lookup(make_addr(tag_pool[w % 4], idx_pool[w % 3], w));  // empty cache misses
    end
    rand_line(l);
    fill(make_addr(tag_pool[0], idx_pool[0], 0), l);
    for (int w = 0; w < 8; w++)
    begin
      lookup(make_addr(tag_pool[0], idx_pool[0], w));  // back-to-back hits
    end
    rand_line(l);
    fill(make_addr(tag_pool[1], idx_pool[0], 0), l);  // set now full
    lookup(make_addr(tag_pool[0], idx_pool[0], 3));
    lookup(make_addr(tag_pool[1], idx_pool[0], 6));
    idle_cycle();
    lookup(make_addr(tag_pool[1], idx_pool[0], 2));   // tag 0 becomes the victim
    idle_cycle();
    rand_line(l);
    fill(make_addr(tag_pool[2], idx_pool[0], 0), l);  // evicts tag 0
    lookup(make_addr(tag_pool[0], idx_pool[0], 1));
    lookup(make_addr(tag_pool[1], idx_pool[0], 4));
    lookup(make_addr(tag_pool[2], idx_pool[0], 7));
    rand_line(l);
    fill_and_lookup(make_addr(tag_pool[3], idx_pool[1], 0), l,
                    make_addr(tag_pool[2], idx_pool[0], 5));
    lookup(make_addr(tag_pool[3], idx_pool[1], 5));
    idle_cycle();
    // random mix
    for (int n = 0; n < RAND_OPS; n++)
    begin
      sel = {$random(seed)} % 100;
      pick_addr(a);
      pick_addr(b);
      rand_line(l);
      if (sel < 25)
        fill(a, l);
      else if (sel < 33)
        fill_and_lookup(a, l, b);
      else if (sel < 85)
        lookup(a);
      else
        idle_cycle();
    end
    repeat (4) idle_cycle();  // drain the pipeline
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0d responses were still outstanding at the end", exp_q.size());
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    #((TOTAL_OPS + 100) * 4);
    $display("the run did not finish within %0d ns", (TOTAL_OPS + 100) * 4);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tests/icache_properties.sv
`timescale 1ns/1ps

module icache_properties (
  input logic clk,
  input logic rst_n,
  input logic i_req_valid,
  input logic o_req_ready,
  input logic i_fill_valid,
  input logic o_rsp_valid,
  input logic o_rsp_hit
);

  logic accept;  // lookup taken at this edge

  assign accept = i_req_valid & o_req_ready;

  // ------------------------------
  // response framing
  // ------------------------------
  a_hit_needs_valid : assert property (@(posedge clk) disable iff (rst_n)
    o_rsp_hit |-> o_rsp_valid)
    else $error("o_rsp_hit high while o_rsp_valid is low");

  // visible after the next edge, so sampled two edges on
  a_rsp_after_accept : assert property (@(posedge clk) disable iff (rst_n)
    accept |-> ##2 o_rsp_valid)
    else $error("no response one edge after an accepted lookup");

  a_no_stray_rsp : assert property (@(posedge clk) disable iff (rst_n)
    o_rsp_valid |-> $past(accept, 2))
    else $error("response without a matching lookup");

  // ------------------------------
  // arbitration
  // ------------------------------
  a_fill_blocks_req : assert property (@(posedge clk) disable iff (rst_n)
    i_fill_valid |-> !o_req_ready)
    else $error("o_req_ready high during a fill");

endmodule

bind icache_top icache_properties u_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .i_req_valid  (i_req_valid),
  .o_req_ready  (o_req_ready),
  .i_fill_valid (i_fill_valid),
  .o_rsp_valid  (o_rsp_valid),
  .o_rsp_hit    (o_rsp_hit)
);

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
  parameter int DEPTH = 128  // sets per way
) (
  input  logic  clk,
  input  logic  rst_n,

  // lookup request
  input  logic  i_req_valid,
  input  addr_t i_req_addr,
  output logic  o_req_ready,

  // refill
  input  logic  i_fill_valid,
  input  fill_t i_fill,

  // response, no back-pressure
  output logic  o_rsp_valid,
  output logic  o_rsp_hit,
  output word_t o_rsp_instr
);

  // ------------------------------
  // stage wiring
  // ------------------------------
  ram_cmd_t   cmd;       // decode -> execute
  lookup_t    lookup;    // decode -> execute
  way_read_t  way_read;  // execute -> result
  logic [1:0] hit_way;   // result -> execute, lru

  // arbitration and address split, combinational
  icache_decode u_decode (
    .i_req_valid  (i_req_valid),
    .i_req_addr   (i_req_addr),
    .i_fill_valid (i_fill_valid),
    .i_fill       (i_fill),
    .o_req_ready  (o_req_ready),
    .o_cmd        (cmd),
    .o_lookup     (lookup)
  );

  // tag/data rams, valid and lru, tag compare
  icache_execute #(
    .DEPTH (DEPTH)
  ) u_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_cmd         (cmd),
    .i_lookup      (lookup),
    .i_rsp_hit_way (hit_way),
    .o_read        (way_read)
  );

  // word select and response register
  icache_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_read      (way_read),
    .o_hit_way   (hit_way),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_hit   (o_rsp_hit),
    .o_rsp_instr (o_rsp_instr)
  );

endmodule

// File: source/icache_result.sv
`timescale 1ns/1ps

module icache_result import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  way_read_t  i_read,
  output logic [1:0] o_hit_way,    // one-hot, to the lru update
  output logic       o_rsp_valid,
  output logic       o_rsp_hit,
  output word_t      o_rsp_instr
);

  // ------------------------------
  // word select
  // ------------------------------
  logic  any_hit;
  line_t sel_line;
  word_t sel_word;

  assign any_hit  = |i_read.hit;
  assign sel_line = i_read.hit[0] ? i_read.line[0] : i_read.line[1];  // way 0 first

  // zero on a miss and when idle
  assign sel_word = any_hit ? sel_line[i_read.lookup.word_sel*WORD_W +: WORD_W] : '0;

  // same priority as the line mux
  assign o_hit_way = {i_read.hit[1] & ~i_read.hit[0], i_read.hit[0]};

  // ------------------------------
  // response register
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (rst_n)
    begin
      o_rsp_valid <= 1'b0;
      o_rsp_hit   <= 1'b0;
    end
    else
    begin
      o_rsp_valid <= i_read.lookup.valid;  // exactly one cycle per lookup
      o_rsp_hit   <= any_hit;
    end
  end

  // instruction, already zero when not hit
  always_ff @(posedge clk)
  begin
    o_rsp_instr <= sel_word;
  end

endmodule

// File: source/icache_execute.sv
`timescale 1ns/1ps

module icache_execute import icache_pkg::*; #(
  parameter int DEPTH = 128  // sets
) (
  input  logic       clk,
  input  logic       rst_n,
  input  ram_cmd_t   i_cmd,
  input  lookup_t    i_lookup,
  input  logic [1:0] i_rsp_hit_way,  // way hit by the response at this edge
  output way_read_t  o_read
);

  // ------------------------------
  // state
  // ------------------------------
  logic [1:0][DEPTH-1:0] valid_q;  // per way, per set
  logic [DEPTH-1:0]      lru_q;    // set value is the next victim way

  lookup_t    look_q;    // lookup matching the ram read data
  index_t     idx_q;     // its set, for the lru update
  logic [1:0] rd_vld_q;  // valid bits sampled with the read

  logic       victim;    // fill target way
  logic [1:0] way_we;
  logic [1:0] way_en;
  tag_t  [1:0] rd_tag;
  line_t [1:0] rd_line;
  logic  [1:0] hit;

  // ------------------------------
  // victim and port control
  // ------------------------------
  assign victim = lru_q[i_cmd.index];

  assign way_we[0] = i_cmd.we & ~victim;
  assign way_we[1] = i_cmd.we &  victim;

  // a lookup reads both ways, a fill touches the victim only
  assign way_en = way_we | {2{i_lookup.valid}};

  // ------------------------------
  // way storage
  // ------------------------------
  for (genvar w = 0; w < 2; w++)
  begin : g_way
    cache_ram #(
      .DEPTH   (DEPTH),
      .entry_t (tag_t)
    ) u_tag_ram (
      .clk     (clk),
      .i_en    (way_en[w]),
      .i_we    (way_we[w]),
      .i_index (i_cmd.index),
      .i_wdata (i_cmd.wtag),
      .o_rdata (rd_tag[w])
    );

    cache_ram #(
      .DEPTH   (DEPTH),
      .entry_t (line_t)
    ) u_data_ram (
      .clk     (clk),
      .i_en    (way_en[w]),
      .i_we    (way_we[w]),
      .i_index (i_cmd.index),
      .i_wdata (i_cmd.wline),
      .o_rdata (rd_line[w])
    );

    // tag compare against the registered lookup
    assign hit[w] = look_q.valid & rd_vld_q[w] & (rd_tag[w] == look_q.tag);
  end

  // ------------------------------
  // valid, lru, lookup register
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (rst_n)
    begin
      valid_q  <= '0;
      lru_q    <= '0;
      look_q   <= '0;
      rd_vld_q <= '0;
    end
    else
    begin
      // hit points the set at the other way
      if (i_rsp_hit_way != 2'b00)
      begin
        lru_q[idx_q] <= i_rsp_hit_way[0];
      end
      // fill comes later, so it wins on the same set
      if (i_cmd.fill)
      begin
        lru_q[i_cmd.index]           <= ~victim;
        valid_q[victim][i_cmd.index] <= 1'b1;
      end
      look_q <= i_lookup;
      if (i_lookup.valid)
      begin
        rd_vld_q <= {valid_q[1][i_cmd.index], valid_q[0][i_cmd.index]};
      end
    end
  end

  // set index, payload only
  always_ff @(posedge clk)
  begin
    if (i_lookup.valid)
    begin
      idx_q <= i_cmd.index;
    end
  end

  // ------------------------------
  // to result
  // ------------------------------
  assign o_read.lookup = look_q;
  assign o_read.hit    = hit;
  assign o_read.line   = rd_line;

endmodule

// File: source/icache_decode.sv
`timescale 1ns/1ps

module icache_decode import icache_pkg::*; (
  // lookup side
  input  logic     i_req_valid,
  input  addr_t    i_req_addr,

  // fill side, always wins
  input  logic     i_fill_valid,
  input  fill_t    i_fill,

  output logic     o_req_ready,
  output ram_cmd_t o_cmd,
  output lookup_t  o_lookup
);

  // byte bits below the word number
  localparam int WORD_LSB = OFFSET_BITS - WORD_SEL_W;

  // ------------------------------
  // arbitration
  // ------------------------------
  logic      accept;    // lookup goes to the rams this cycle
  addr_t     win_addr;  // address of the winner
  tag_t      win_tag;
  index_t    win_index;
  word_sel_t win_word;

  // one port per ram, so a fill blocks the lookup
  assign o_req_ready = ~i_fill_valid;
  assign accept      = i_req_valid & o_req_ready;

  assign win_addr = i_fill_valid ? i_fill.addr : i_req_addr;

  // ------------------------------
  // address split
  // ------------------------------
  // | tag 31:12 | index 11:5 | word 4:2 | byte 1:0 |
  assign win_tag   = win_addr[ADDR_W-1 -: TAG_W];
  assign win_index = win_addr[OFFSET_BITS +: INDEX_BITS];
  assign win_word  = win_addr[WORD_LSB +: WORD_SEL_W];  // meaningless for a fill

  // ------------------------------
  // ram command
  // ------------------------------
  always_comb
  begin
    o_cmd.index = win_index;     // read or write set
    o_cmd.we    = i_fill_valid;  // write, else read
    o_cmd.fill  = i_fill_valid;  // valid/lru update in execute
    o_cmd.wtag  = win_tag;       // only taken when we
    o_cmd.wline = i_fill.line;
  end

  // lookup that rides along with the read
  always_comb
  begin
    o_lookup.valid    = accept;
    o_lookup.tag      = win_tag;
    o_lookup.word_sel = win_word;
  end

endmodule

// File: source/cache_ram.sv
`timescale 1ns/1ps

// single port, registered read, maps onto a memory macro
module cache_ram import icache_pkg::*; #(
  parameter int  DEPTH   = 128,     // entries
  parameter type entry_t = line_t   // tag or line
) (
  input  logic   clk,
  input  logic   i_en,     // port enable
  input  logic   i_we,     // write, else read
  input  index_t i_index,
  input  entry_t i_wdata,
  output entry_t o_rdata
);

  // ------------------------------
  // storage
  // ------------------------------
  entry_t mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (i_en)
    begin
      if (i_we)
      begin
        mem[i_index] <= i_wdata;
      end
      else
      begin
        o_rdata <= mem[i_index];  // holds across writes and idle
      end
    end
  end

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int ADDR_W      = 32;   // fetch address
  localparam int LINE_W      = 256;  // eight words per line
  localparam int WORD_W      = 32;   // one instruction
  localparam int OFFSET_BITS = 5;    // byte offset inside a line
  localparam int INDEX_BITS  = 7;    // 128 sets
  localparam int TAG_W       = ADDR_W - INDEX_BITS - OFFSET_BITS;  // 20
  localparam int WORD_SEL_W  = 3;    // word number inside a line

  // ------------------------------
  // field types
  // ------------------------------
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;

  // refill from the next level, always a whole line
  typedef struct packed {
    addr_t addr;   // any address inside the line
    line_t line;   // word 0 in the low bits
  } fill_t;

  // ------------------------------
  // stage structs
  // ------------------------------

  // one command word to the way storage
  typedef struct packed {
    index_t index;  // set for both read and write
    logic   we;     // ram write, victim way only
    logic   fill;   // valid and lru update
    tag_t   wtag;   // tag of the fill
    line_t  wline;  // line of the fill
  } ram_cmd_t;

  // a lookup in flight
  typedef struct packed {
    logic      valid;
    tag_t      tag;
    word_sel_t word_sel;
  } lookup_t;

  // handed from the compare stage to the output stage
  typedef struct packed {
    lookup_t       lookup;
    logic [1:0]    hit;    // one bit per way
    line_t [1:0]   line;   // both ways as read
  } way_read_t;

endpackage
